// ==== hw/fetch_consts.svh ====
//////////////////////////////////////////////////
// fetch front end constants
// predictor history width, btb size, queue depth
// branch result codes shared with the back end
//////////////////////////////////////////////////

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// global history and pattern table index width
`define HISTORY_BITS 8

`define BTB_INDEX_BITS 5   // 32 btb entries
`define QUEUE_DEPTH    8   // fetch queue entries

// result codes returned by branch resolution
`define BRANCH_NONE      2'd0
`define BRANCH_NOT_TAKEN 2'd1
`define BRANCH_TAKEN     2'd2

`endif

// ==== hw/resolve_types_pkg.sv ====
//////////////////////////////////////////////////
// branch resolution types
// result enum and the per-slot update record
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

package resolve_types_pkg;

  // same encoding as the BRANCH_* codes
  typedef enum logic [1:0] {
    RESULT_NONE      = `BRANCH_NONE,
    RESULT_NOT_TAKEN = `BRANCH_NOT_TAKEN,
    RESULT_TAKEN     = `BRANCH_TAKEN
  } branch_result_t;

  typedef struct packed {
    branch_result_t           result;     // none when the slot is idle
    logic [63:0]              npc;        // pc+4 of the resolved branch
    logic [63:0]              target;     // computed pc
    logic [`HISTORY_BITS-1:0] pht_index;  // index it was predicted with
  } resolve_t;

endpackage

`default_nettype wire

// ==== hw/fetch_types_pkg.sv ====
//////////////////////////////////////////////////
// fetch side types
// instruction word with branch and memory views
// fetched slot record kept in the queue
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

package fetch_types_pkg;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;   // word displacement, signed
  } branch_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } mem_fmt_t;

  // one 32-bit word, read either way by the predecoder
  typedef union packed {
    logic [31:0] raw;
    branch_fmt_t branch_fmt;
    mem_fmt_t    mem_fmt;
  } inst_word_u;

  typedef struct packed {
    inst_word_u               inst;
    logic [63:0]              pc;
    logic [63:0]              ppc;         // predicted next pc
    logic                     pred_taken;
    logic [`HISTORY_BITS-1:0] pht_index;
  } fetch_slot_t;

endpackage

`default_nettype wire

// ==== hw/fetch_pair_if.sv ====
//////////////////////////////////////////////////
// fetched instruction pair, fetch stage to queue
// producer and consumer modports
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface fetch_pair_if
  import fetch_types_pkg::*;
();

  logic        valid1;  // low on stall or second-word entry
  logic        valid2;  // low on stall
  fetch_slot_t slot1;   // lower word of the pair
  fetch_slot_t slot2;   // upper word

  modport producer (
    output valid1,
    output valid2,
    output slot1,
    output slot2
  );

  modport consumer (
    input valid1,
    input valid2,
    input slot1,
    input slot2
  );

endinterface

`default_nettype wire

// ==== hw/branch_predictor.sv ====
//////////////////////////////////////////////////
// global history branch predictor
// 2-bit counter table indexed by pc xor history
// trained from resolution results
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module branch_predictor
  import resolve_types_pkg::*;
(
  input  wire                            clock,
  input  wire                            reset,
  input  wire  [63:0]                    pc1,
  input  wire  [63:0]                    pc2,
  input  wire  resolve_t                 res1,
  input  wire  resolve_t                 res2,
  output logic                           pred1,
  output logic                           pred2,
  output logic [`HISTORY_BITS-1:0]       index1,
  output logic [`HISTORY_BITS-1:0]       index2
);

  localparam int PHT_SIZE = 1 << `HISTORY_BITS;

  logic [1:0]               pht [PHT_SIZE];  // saturating counters
  logic [`HISTORY_BITS-1:0] ghr;             // newest outcome in bit 0
  logic [`HISTORY_BITS-1:0] ghr_next;
  logic                     upd1;
  logic                     upd2;
  logic                     taken1;
  logic                     taken2;
  logic [1:0]               base2;           // counter slot 2 trains from

  function automatic logic [1:0] train(input logic [1:0] ctr, input logic taken);
    if (taken)
      return (ctr == 2'b11) ? ctr : ctr + 2'd1;
    else
      return (ctr == 2'b00) ? ctr : ctr - 2'd1;
  endfunction

  assign index1 = pc1[`HISTORY_BITS+1:2] ^ ghr;
  assign index2 = pc2[`HISTORY_BITS+1:2] ^ ghr;
  assign pred1  = pht[index1][1];  // msb set means taken
  assign pred2  = pht[index2][1];

  assign upd1   = (res1.result != RESULT_NONE);
  assign upd2   = (res2.result != RESULT_NONE);
  assign taken1 = (res1.result == RESULT_TAKEN);
  assign taken2 = (res2.result == RESULT_TAKEN);

  // both slots on one counter, slot 2 sees slot 1's training
  assign base2 = (upd1 && res1.pht_index == res2.pht_index) ?
                 train(pht[res1.pht_index], taken1) : pht[res2.pht_index];

  always_comb
  begin
    ghr_next = ghr;
    if (upd1)
      ghr_next = {ghr_next[`HISTORY_BITS-2:0], taken1};
    if (upd2)
      ghr_next = {ghr_next[`HISTORY_BITS-2:0], taken2};  // older branch first
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      ghr <= '0;
      for (int i = 0; i < PHT_SIZE; i++)
        pht[i] <= 2'b01;  // weakly not taken
    end
    else
    begin
      ghr <= ghr_next;
      if (upd1)
        pht[res1.pht_index] <= train(pht[res1.pht_index], taken1);
      if (upd2)
        pht[res2.pht_index] <= train(base2, taken2);
    end
  end

  // history only moves on resolved branches
  assert property (@(posedge clock) disable iff (reset)
    !(upd1 || upd2) |=> $stable(ghr));

endmodule

`default_nettype wire

// ==== hw/branch_target_buffer.sv ====
//////////////////////////////////////////////////
// branch target buffer
// direct mapped tag/target/valid table
// looked up by next pc, filled on taken results
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module branch_target_buffer
  import resolve_types_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  input  wire  [63:0]      pc1,      // next pc of slot 1
  input  wire  [63:0]      pc2,
  input  wire  resolve_t   res1,
  input  wire  resolve_t   res2,
  output logic [63:0]      target1,
  output logic [63:0]      target2,
  output logic             hit1,
  output logic             hit2
);

  localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
  localparam int TAG_LO   = `BTB_INDEX_BITS + 2;
  localparam int TAG_BITS = 64 - TAG_LO;

  logic [TAG_BITS-1:0]        tags    [ENTRIES];
  logic [63:0]                targets [ENTRIES];
  logic [ENTRIES-1:0]         valid;             // all clear after reset
  logic [`BTB_INDEX_BITS-1:0] rd_idx1;
  logic [`BTB_INDEX_BITS-1:0] rd_idx2;
  logic [`BTB_INDEX_BITS-1:0] wr_idx1;
  logic [`BTB_INDEX_BITS-1:0] wr_idx2;
  logic                       wr1;
  logic                       wr2;

  ////////////////////////////////////////////////
  // lookup
  assign rd_idx1 = pc1[TAG_LO-1:2];
  assign rd_idx2 = pc2[TAG_LO-1:2];
  assign hit1    = valid[rd_idx1] && (tags[rd_idx1] == pc1[63:TAG_LO]);
  assign hit2    = valid[rd_idx2] && (tags[rd_idx2] == pc2[63:TAG_LO]);
  assign target1 = targets[rd_idx1];
  assign target2 = targets[rd_idx2];

  ////////////////////////////////////////////////
  // update
  assign wr1     = (res1.result == RESULT_TAKEN);
  assign wr2     = (res2.result == RESULT_TAKEN);
  assign wr_idx1 = res1.npc[TAG_LO-1:2];
  assign wr_idx2 = res2.npc[TAG_LO-1:2];

  always_ff @(posedge clock)
  begin
    if (reset)
      valid <= '0;
    else
    begin
      if (wr1)
        valid[wr_idx1] <= 1'b1;
      if (wr2)
        valid[wr_idx2] <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (wr1)
    begin
      tags[wr_idx1]    <= res1.npc[63:TAG_LO];
      targets[wr_idx1] <= res1.target;
    end
    if (wr2)  // later slot lands last
    begin
      tags[wr_idx2]    <= res2.npc[63:TAG_LO];
      targets[wr_idx2] <= res2.target;
    end
  end

  // two taken slots on one entry must agree on the target
  assert property (@(posedge clock) disable iff (reset)
    !(wr1 && wr2 && wr_idx1 == wr_idx2 && res1.target != res2.target));

endmodule

`default_nettype wire

// ==== hw/if_stage.sv ====
//////////////////////////////////////////////////
// instruction fetch stage
// pc register and instruction memory address
// slot validity, predicted pc, redirect on taken
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module if_stage
  import resolve_types_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  input  wire             stall,       // queue cannot take a pair
  input  wire  resolve_t  res1,
  input  wire  resolve_t  res2,
  input  wire  [63:0]     imem_data,
  input  wire             imem_valid,
  output logic [63:0]     imem_addr,
  output logic            flush,       // any taken result this cycle
  fetch_pair_if.producer  pair
);

  logic [63:0]              pc;          // pc being fetched
  logic [63:0]              next_pc;
  logic [63:0]              pc1;
  logic [63:0]              pc2;
  logic [63:0]              npc1;
  logic [63:0]              npc2;
  logic                     taken1;
  logic                     taken2;
  logic                     fetch_en;    // low for the first cycle out of reset
  logic                     stalling;
  logic                     pred1;
  logic                     pred2;
  logic                     hit1;
  logic                     hit2;
  logic [63:0]              btb_target1;
  logic [63:0]              btb_target2;
  logic [`HISTORY_BITS-1:0] index1;
  logic [`HISTORY_BITS-1:0] index2;

  assign taken1 = (res1.result == RESULT_TAKEN);
  assign taken2 = (res2.result == RESULT_TAKEN);
  assign flush  = taken1 | taken2;

  assign pc1       = {pc[63:3], 3'b000};  // aligned pair, lower word
  assign pc2       = {pc[63:3], 3'b100};
  assign npc1      = pc1 + 64'd4;
  assign npc2      = pc2 + 64'd4;        // also the next aligned pair
  assign imem_addr = pc1;

  assign stalling = stall | ~imem_valid | ~fetch_en;

  // slot 1 result wins over slot 2 and both win over a stall
  assign next_pc = taken1   ? res1.target :
                   taken2   ? res2.target :
                   stalling ? pc          : npc2;

  ////////////////////////////////////////////////
  // outgoing pair
  always_comb
  begin
    pair.valid1           = ~(pc[2] | stalling);
    pair.valid2           = ~stalling;
    pair.slot1.inst.raw   = imem_data[31:0];
    pair.slot1.pc         = pc1;
    pair.slot1.pred_taken = pred1 & hit1;
    pair.slot1.ppc        = (pred1 & hit1) ? btb_target1 : npc1;
    pair.slot1.pht_index  = index1;
    pair.slot2.inst.raw   = imem_data[63:32];
    pair.slot2.pc         = pc2;
    pair.slot2.pred_taken = pred2 & hit2;
    pair.slot2.ppc        = (pred2 & hit2) ? btb_target2 : npc2;
    pair.slot2.pht_index  = index2;
  end

  branch_predictor i_branch_predictor (
    .clock  (clock),
    .reset  (reset),
    .pc1    (pc1),
    .pc2    (pc2),
    .res1   (res1),
    .res2   (res2),
    .pred1  (pred1),
    .pred2  (pred2),
    .index1 (index1),
    .index2 (index2)
  );

  // btb keyed by next pc like the resolved npc
  branch_target_buffer i_branch_target_buffer (
    .clock   (clock),
    .reset   (reset),
    .pc1     (npc1),
    .pc2     (npc2),
    .res1    (res1),
    .res2    (res2),
    .target1 (btb_target1),
    .target2 (btb_target2),
    .hit1    (hit1),
    .hit2    (hit2)
  );

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc       <= '0;
      fetch_en <= 1'b0;
    end
    else
    begin
      pc       <= next_pc;
      fetch_en <= 1'b1;
    end
  end

  // fetch entering at the second word never sends slot 1
  assert property (@(posedge clock) disable iff (reset)
    pc[2] |-> !pair.valid1);

endmodule

`default_nettype wire

// ==== hw/fetch_queue.sv ====
//////////////////////////////////////////////////
// fetch queue
// circular buffer, up to two in and one out
// flush on redirect, stall level to fetch
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_queue
  import fetch_types_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  input  wire             flush,
  fetch_pair_if.consumer  pair,
  input  wire             pop,
  output logic            head_valid,
  output fetch_slot_t     head,
  output logic            stall
);

  localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);

  fetch_slot_t         entries [`QUEUE_DEPTH];
  logic [PTR_BITS-1:0] head_ptr;
  logic [PTR_BITS-1:0] tail_ptr;
  logic [PTR_BITS-1:0] slot2_ptr;   // behind slot 1 when both arrive
  logic [PTR_BITS:0]   count;
  logic [1:0]          push_n;
  logic                do_pop;

  assign push_n     = {1'b0, pair.valid1} + {1'b0, pair.valid2};
  assign slot2_ptr  = pair.valid1 ? tail_ptr + 1'b1 : tail_ptr;
  assign do_pop     = pop & head_valid;
  assign head_valid = (count != '0);
  assign head       = entries[head_ptr];
  assign stall      = (count > `QUEUE_DEPTH - 2);  // room for a full pair

  always_ff @(posedge clock)
  begin
    if (reset || flush)  // redirect drops everything queued
    begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end
    else
    begin
      head_ptr <= head_ptr + do_pop;
      tail_ptr <= tail_ptr + push_n;
      count    <= count + push_n - do_pop;
    end
  end

  always_ff @(posedge clock)
  begin
    if (pair.valid1)
      entries[tail_ptr] <= pair.slot1;
    if (pair.valid2)
      entries[slot2_ptr] <= pair.slot2;
  end

  // fetch honors stall
  assert property (@(posedge clock) disable iff (reset || flush)
    (push_n != 2'd0) |-> (count + push_n <= `QUEUE_DEPTH));

  // predecoder only pops a live head
  assert property (@(posedge clock) disable iff (reset) pop |-> head_valid);

endmodule

`default_nettype wire

// ==== hw/branch_predecode.sv ====
//////////////////////////////////////////////////
// branch predecoder
// output register toward decode
// branch format target and memory format jump
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module branch_predecode
  import fetch_types_pkg::*;
(
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       flush,
  input  wire                       head_valid,
  input  wire  fetch_slot_t         head,
  input  wire                       dec_ready,
  output logic                      pop,
  output logic                      dec_valid,
  output logic [63:0]               dec_pc,
  output logic [31:0]               dec_inst,
  output logic [63:0]               dec_ppc,
  output logic                      dec_pred_taken,
  output logic [`HISTORY_BITS-1:0]  dec_pht_index,
  output logic                      dec_is_branch,
  output logic                      dec_is_jump,
  output logic [63:0]               dec_direct_target
);

  logic        load;            // register empty or draining
  logic        is_branch;
  logic        is_jump;
  logic [63:0] disp_bytes;      // sign extended, times four
  logic [63:0] direct_target;

  assign load = ~dec_valid | dec_ready;
  assign pop  = load & head_valid;

  // opcodes 0x30 to 0x3f are branch format
  assign is_branch     = (head.inst.branch_fmt.opcode[5:4] == 2'b11);
  assign is_jump       = (head.inst.mem_fmt.opcode == 6'h1A);
  assign disp_bytes    = {{41{head.inst.branch_fmt.disp[20]}},
                          head.inst.branch_fmt.disp, 2'b00};
  assign direct_target = head.pc + 64'd4 + disp_bytes;

  always_ff @(posedge clock)
  begin
    if (reset || flush)
      dec_valid <= 1'b0;
    else if (load)
      dec_valid <= head_valid;  // held while decode is not ready
  end

  always_ff @(posedge clock)
  begin
    if (pop)
    begin
      dec_pc            <= head.pc;
      dec_inst          <= head.inst.raw;
      dec_ppc           <= head.ppc;
      dec_pred_taken    <= head.pred_taken;
      dec_pht_index     <= head.pht_index;
      dec_is_branch     <= is_branch;
      dec_is_jump       <= is_jump;
      dec_direct_target <= direct_target;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
//////////////////////////////////////////////////
// fetch front end top level
// fetch stage, fetch queue and predecoder
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_top
  import resolve_types_pkg::*;
  import fetch_types_pkg::*;
(
  input  wire                       clock,
  input  wire                       reset,
  output logic [63:0]               imem_addr,
  input  wire  [63:0]               imem_data,
  input  wire                       imem_valid,
  input  wire  [1:0]                res1_result,
  input  wire  [63:0]               res1_npc,
  input  wire  [63:0]               res1_target,
  input  wire  [`HISTORY_BITS-1:0]  res1_pht_index,
  input  wire  [1:0]                res2_result,
  input  wire  [63:0]               res2_npc,
  input  wire  [63:0]               res2_target,
  input  wire  [`HISTORY_BITS-1:0]  res2_pht_index,
  input  wire                       dec_ready,
  output logic                      dec_valid,
  output logic [63:0]               dec_pc,
  output logic [31:0]               dec_inst,
  output logic [63:0]               dec_ppc,
  output logic                      dec_pred_taken,
  output logic [`HISTORY_BITS-1:0]  dec_pht_index,
  output logic                      dec_is_branch,
  output logic                      dec_is_jump,
  output logic [63:0]               dec_direct_target
);

  resolve_t    res1;
  resolve_t    res2;
  logic        stall;
  logic        flush;
  logic        head_valid;
  fetch_slot_t head;
  logic        pop;

  fetch_pair_if pair ();

  // back end results, one record per slot
  assign res1 = '{result: branch_result_t'(res1_result), npc: res1_npc,
                  target: res1_target, pht_index: res1_pht_index};
  assign res2 = '{result: branch_result_t'(res2_result), npc: res2_npc,
                  target: res2_target, pht_index: res2_pht_index};

  if_stage i_if_stage (
    .clock      (clock),
    .reset      (reset),
    .stall      (stall),
    .res1       (res1),
    .res2       (res2),
    .imem_data  (imem_data),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .flush      (flush),
    .pair       (pair)
  );

  fetch_queue i_fetch_queue (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .pair       (pair),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head),
    .stall      (stall)
  );

  branch_predecode i_branch_predecode (
    .clock             (clock),
    .reset             (reset),
    .flush             (flush),
    .head_valid        (head_valid),
    .head              (head),
    .dec_ready         (dec_ready),
    .pop               (pop),
    .dec_valid         (dec_valid),
    .dec_pc            (dec_pc),
    .dec_inst          (dec_inst),
    .dec_ppc           (dec_ppc),
    .dec_pred_taken    (dec_pred_taken),
    .dec_pht_index     (dec_pht_index),
    .dec_is_branch     (dec_is_branch),
    .dec_is_jump       (dec_is_jump),
    .dec_direct_target (dec_direct_target)
  );

endmodule

`default_nettype wire

// ==== bench/fetch_tb.sv ====
//////////////////////////////////////////////////
// fetch front end testbench
// clock, reset, instruction memory model
// branch resolver with expected pc model
// order, redirect, back-pressure, prediction
// and predecode checks, watchdog
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;

  localparam int          CLOCK_PERIOD  = 20;
  localparam int          RESET_CYCLES  = 16;
  localparam int          LOOP_COUNT    = 10;     // taken resolutions of the loop branch
  localparam int          MAX_CYCLES    = 2000;   // generous for LOOP_COUNT iterations
  localparam int          RESOLVE_DELAY = 3;      // cycles from accept to result
  localparam logic [63:0] BRANCH_PC     = 64'h40;
  localparam logic [63:0] BRANCH_TARGET = 64'h104;
  localparam logic [63:0] JUMP_PC       = 64'h120;  // returns to the loop branch

  logic                       clock;
  logic                       reset;
  logic [63:0]                imem_addr;
  logic [63:0]                imem_data;
  logic                       imem_valid;
  logic [1:0]                 res1_result;
  logic [63:0]                res1_npc;
  logic [63:0]                res1_target;
  logic [`HISTORY_BITS-1:0]   res1_pht_index;
  logic [1:0]                 res2_result;
  logic [63:0]                res2_npc;
  logic [63:0]                res2_target;
  logic [`HISTORY_BITS-1:0]   res2_pht_index;
  logic                       dec_ready;
  logic                       dec_valid;
  logic [63:0]                dec_pc;
  logic [31:0]                dec_inst;
  logic [63:0]                dec_ppc;
  logic                       dec_pred_taken;
  logic [`HISTORY_BITS-1:0]   dec_pht_index;
  logic                       dec_is_branch;
  logic                       dec_is_jump;
  logic [63:0]                dec_direct_target;

  logic [227+`HISTORY_BITS:0] dec_bundle;     // every dec_ output in one word
  logic [227+`HISTORY_BITS:0] held_bundle;
  logic                       holding;        // decode stalled last edge
  logic                       redirect;
  logic                       entry_check;    // next accept must be the branch target
  logic [31:0]                rng;
  logic [63:0]                expected_pc;
  logic [63:0]                resolved_target [logic [63:0]];  // keyed by branch pc
  logic [63:0]                pending_npc;
  logic [63:0]                pending_target;
  logic [`HISTORY_BITS-1:0]   pending_index;
  int                         resolve_wait;
  int                         branch_resolutions;
  logic                       seen_pred_branch;

  //////////////////////////////////////////////////
  // memory model and helpers

  // filler is opcode 0x08 and never branch or jump format
  function automatic logic [31:0] inst_at(input logic [63:0] addr);
    logic [25:0] fill;
    fill = addr[27:2] ^ addr[53:28] ^ {16'd0, addr[63:54]};
    if (addr == BRANCH_PC)
      return {6'h30, 5'd3, 21'h30};          // 0x44 + 0x30 words = 0x104
    else if (addr == JUMP_PC)
      return {6'h1A, 5'd31, 5'd1, 16'h0};    // the one memory format jump
    else
      return {6'h08, fill};
  endfunction

  function automatic logic [63:0] mem_pair(input logic [63:0] addr);
    return {inst_at({addr[63:3], 3'b100}), inst_at({addr[63:3], 3'b000})};
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] seed);
    return seed * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic show_mismatch(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
    $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("error %s", what);
    abort_run();
  endtask

  //////////////////////////////////////////////////
  // dut

  assign imem_data  = mem_pair(imem_addr);   // combinational read in the same cycle
  assign dec_bundle = {dec_valid, dec_pc, dec_inst, dec_ppc, dec_pred_taken,
                       dec_pht_index, dec_is_branch, dec_is_jump, dec_direct_target};

  fetch_top i_fetch_top (
    .clock             (clock),
    .reset             (reset),
    .imem_addr         (imem_addr),
    .imem_data         (imem_data),
    .imem_valid        (imem_valid),
    .res1_result       (res1_result),
    .res1_npc          (res1_npc),
    .res1_target       (res1_target),
    .res1_pht_index    (res1_pht_index),
    .res2_result       (res2_result),
    .res2_npc          (res2_npc),
    .res2_target       (res2_target),
    .res2_pht_index    (res2_pht_index),
    .dec_ready         (dec_ready),
    .dec_valid         (dec_valid),
    .dec_pc            (dec_pc),
    .dec_inst          (dec_inst),
    .dec_ppc           (dec_ppc),
    .dec_pred_taken    (dec_pred_taken),
    .dec_pht_index     (dec_pht_index),
    .dec_is_branch     (dec_is_branch),
    .dec_is_jump       (dec_is_jump),
    .dec_direct_target (dec_direct_target)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  //////////////////////////////////////////////////
  // checks on one instruction taken by decode
  task automatic check_accepted();
    logic [63:0] word;
    logic [31:0] exp_inst;
    logic [63:0] exp_target;
    word       = mem_pair({dec_pc[63:3], 3'b000});
    exp_inst   = dec_pc[2] ? word[63:32] : word[31:0];   // upper half is the second word
    exp_target = dec_pc + 64'd4 + ({{43{exp_inst[20]}}, exp_inst[20:0]} << 2);
    if (entry_check)
      assert (dec_pc == BRANCH_TARGET) else show_mismatch("dec_pc", dec_pc, BRANCH_TARGET);
    entry_check = 1'b0;
    assert (dec_pc == expected_pc) else show_mismatch("dec_pc", dec_pc, expected_pc);
    assert (dec_inst == exp_inst) else show_mismatch("dec_inst", dec_inst, exp_inst);
    assert (dec_is_branch == (exp_inst[31:26] >= 6'h30))
      else show_mismatch("dec_is_branch", dec_is_branch, exp_inst[31:26] >= 6'h30);
    if (dec_is_branch)
      assert (dec_direct_target == exp_target)
        else show_mismatch("dec_direct_target", dec_direct_target, exp_target);
    assert (dec_is_jump == (exp_inst[31:26] == 6'h1A))
      else show_mismatch("dec_is_jump", dec_is_jump, exp_inst[31:26] == 6'h1A);
    // predicted pc is a known target or simply the next word
    if (dec_pred_taken)
    begin
      assert (resolved_target.exists(dec_pc))
        else report_error("taken prediction for a pc that was never resolved");
      assert (dec_ppc == resolved_target[dec_pc])
        else show_mismatch("dec_ppc", dec_ppc, resolved_target[dec_pc]);
    end
    else
      assert (dec_ppc == dec_pc + 64'd4) else show_mismatch("dec_ppc", dec_ppc, dec_pc + 64'd4);
    expected_pc = expected_pc + 64'd4;
    if (dec_pc == BRANCH_PC || dec_pc == JUMP_PC)
    begin
      pending_npc    = dec_pc + 64'd4;
      pending_target = (dec_pc == BRANCH_PC) ? BRANCH_TARGET : BRANCH_PC;
      pending_index  = dec_pht_index;     // index it was predicted with
      resolve_wait   = RESOLVE_DELAY;
      if (dec_pc == BRANCH_PC && dec_pred_taken)
        seen_pred_branch = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus, resolver and monitor
  always @(posedge clock)
  begin
    rng = lcg_step(rng);
    imem_valid <= (rng[22:20] != 3'd0);   // memory misses about one cycle in eight
    dec_ready  <= (rng[27:26] != 2'd0);
    if (!reset)
    begin
      redirect = (res1_result == `BRANCH_TAKEN);
      if (holding)
        assert (dec_bundle == held_bundle)
          else show_mismatch("dec outputs", dec_bundle, held_bundle);
      holding     = dec_valid && !dec_ready && !redirect;
      held_bundle = dec_bundle;
      if (resolve_wait != 0)
      begin
        resolve_wait = resolve_wait - 1;
        if (resolve_wait == 0)
        begin
          res1_result    <= `BRANCH_TAKEN;    // held for one cycle
          res1_npc       <= pending_npc;
          res1_target    <= pending_target;
          res1_pht_index <= pending_index;
          resolved_target[pending_npc - 64'd4] = pending_target;
          if (pending_npc == BRANCH_PC + 64'd4)
            branch_resolutions = branch_resolutions + 1;
        end
      end
      if (redirect)
      begin
        res1_result <= `BRANCH_NONE;
        expected_pc = res1_target;            // whatever decode shows now is flushed
        entry_check = (res1_target == BRANCH_TARGET);
      end
      else if (dec_valid && dec_ready)
        check_accepted();
    end
  end

  initial
  begin
    reset              = 1'b1;
    imem_valid         = 1'b0;
    dec_ready          = 1'b0;
    res1_result        = `BRANCH_NONE;
    res1_npc           = '0;
    res1_target        = '0;
    res1_pht_index     = '0;
    res2_result        = `BRANCH_NONE;   // slot 2 never resolves here
    res2_npc           = '0;
    res2_target        = '0;
    res2_pht_index     = '0;
    rng                = 32'd28;
    expected_pc        = '0;
    holding            = 1'b0;
    redirect           = 1'b0;
    entry_check        = 1'b0;
    resolve_wait       = 0;
    branch_resolutions = 0;
    seen_pred_branch   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    wait (branch_resolutions >= LOOP_COUNT);
    repeat (8) @(posedge clock);
    // counters are trained well before the tenth loop pass
    assert (seen_pred_branch)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      report_error("loop branch at 0x40 was never predicted taken");
  end

  // watchdog
  initial
  begin
    repeat (MAX_CYCLES) @(posedge clock);
    report_error("timeout before the loop branch completed its iterations");
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/resolve_types_pkg.sv
hw/fetch_types_pkg.sv
hw/fetch_pair_if.sv
hw/branch_predictor.sv
hw/branch_target_buffer.sv
hw/if_stage.sv
hw/fetch_queue.sv
hw/branch_predecode.sv
hw/fetch_top.sv
bench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/resolve_types_pkg.sv
      - hw/fetch_types_pkg.sv
      - hw/fetch_pair_if.sv
      - hw/branch_predictor.sv
      - hw/branch_target_buffer.sv
      - hw/if_stage.sv
      - hw/fetch_queue.sv
      - hw/branch_predecode.sv
      - hw/fetch_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/fetch_tb.sv
